// ==== hw/div_pkg.sv ====
`default_nettype none

package div_pkg;

	// operand and result word
	localparam int DATA_W = 32;
	// one extra bit so the trial subtraction can compare unsigned
	localparam int REM_W = DATA_W + 1;
	// holds a count of 0 to DATA_W
	localparam int CNT_W = 6;

	typedef logic [DATA_W-1:0] data_t;
	typedef logic [REM_W-1:0] rem_t;
	typedef logic [CNT_W-1:0] cnt_t;

endpackage

`default_nettype wire

// ==== hw/div_ctrl_pkg.sv ====
`default_nettype none

package div_ctrl_pkg;

	import div_pkg::*;

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_PREP,
		ST_ITER,
		ST_FIX
	} div_state_e;

	// one restoring step per dividend bit at most
	localparam cnt_t MAX_STEPS = cnt_t'(DATA_W);

endpackage

`default_nettype wire

// ==== hw/operand_prep.sv ====
`timescale 1ns/1ps
`default_nettype none

module operand_prep import div_pkg::*; (
	input  logic  clk,
	input  logic  i_rst,
	input  logic  i_load,
	input  data_t i_dividend,
	input  data_t i_divisor,
	output data_t o_dd_norm,
	output data_t o_dr_mag,
	output cnt_t  o_skip,
	output logic  o_q_neg,
	output logic  o_r_neg
);

	data_t dd_mag;
	logic  dd_zero;
	logic  [CNT_W-2:0] lz_bits;

	always_ff @(posedge clk or negedge i_rst) begin
		if (!i_rst) begin
			dd_mag   <= '0;
			o_dr_mag <= '0;
			o_q_neg  <= 1'b0;
			o_r_neg  <= 1'b0;
		end else if (i_load) begin
			dd_mag   <= i_dividend[DATA_W-1] ? data_t'(-i_dividend) : i_dividend;
			o_dr_mag <= i_divisor[DATA_W-1] ? data_t'(-i_divisor) : i_divisor;
			o_q_neg  <= i_dividend[DATA_W-1] ^ i_divisor[DATA_W-1];
			// remainder follows the dividend
			o_r_neg  <= i_dividend[DATA_W-1];
		end
	end

	// leading zero count and normalisation in log2(DATA_W) stages
	for (genvar s = 0; s < CNT_W; s++) begin : g_norm
		data_t word;
		if (s == 0) begin : g_src
			assign word = dd_mag;
		end else begin : g_shift
			// widest window first, then halve it each stage
			assign lz_bits[CNT_W-1-s] =
				~|g_norm[s-1].word[DATA_W-1 -: (1 << (CNT_W-1-s))];
			assign word = lz_bits[CNT_W-1-s] ?
				(g_norm[s-1].word << (1 << (CNT_W-1-s))) : g_norm[s-1].word;
		end
	end

	assign dd_zero = (dd_mag == '0);

	// a zero dividend skips every step
	assign o_skip    = dd_zero ? cnt_t'(DATA_W) : {1'b0, lz_bits};
	assign o_dd_norm = g_norm[CNT_W-1].word;

endmodule

`default_nettype wire

// ==== hw/prefix_subtractor.sv ====
`timescale 1ns/1ps
`default_nettype none

module prefix_subtractor import div_pkg::*; (
	input  rem_t i_a,
	input  rem_t i_b,
	output rem_t o_diff,
	output logic o_no_borrow
);

	rem_t b_inv;
	rem_t half_sum;
	rem_t carry;

	assign b_inv    = ~i_b;
	assign half_sum = i_a ^ b_inv;

	// level 0 is bitwise generate and propagate
	// odd levels then run Kogge-Stone on odd bit positions only
	for (genvar l = 0; l <= $clog2(REM_W - 1); l++) begin : g_lvl
		rem_t g;
		rem_t p;
		if (l == 0) begin : g_init
			assign p = half_sum;
			// carry in of one folded into bit 0
			assign g = {i_a[REM_W-1:1] & b_inv[REM_W-1:1], i_a[0] | b_inv[0]};
		end else begin : g_tree
			for (genvar i = 0; i < REM_W; i++) begin : g_bit
				if ((i % 2 == 1) && (i >= (1 << (l - 1)))) begin : g_op
					assign g[i] = g_lvl[l-1].g[i] |
						(g_lvl[l-1].p[i] & g_lvl[l-1].g[i - (1 << (l - 1))]);
					assign p[i] = g_lvl[l-1].p[i] & g_lvl[l-1].p[i - (1 << (l - 1))];
				end else begin : g_pass
					assign g[i] = g_lvl[l-1].g[i];
					assign p[i] = g_lvl[l-1].p[i];
				end
			end
		end
	end

	// final even level picks up the finished odd neighbour
	for (genvar i = 0; i < REM_W; i++) begin : g_even
		if ((i % 2 == 0) && (i > 0)) begin : g_op
			assign carry[i] = g_lvl[$clog2(REM_W - 1)].g[i] |
				(g_lvl[$clog2(REM_W - 1)].p[i] & g_lvl[$clog2(REM_W - 1)].g[i-1]);
		end else begin : g_pass
			assign carry[i] = g_lvl[$clog2(REM_W - 1)].g[i];
		end
	end

	assign o_diff = half_sum ^ {carry[REM_W-2:0], 1'b1};

	// carry out set means i_a >= i_b
	assign o_no_borrow = carry[REM_W-1];

endmodule

`default_nettype wire

// ==== hw/restoring_datapath.sv ====
`timescale 1ns/1ps
`default_nettype none

module restoring_datapath import div_pkg::*; (
	input  logic  clk,
	input  logic  i_rst,
	input  logic  i_init,
	input  logic  i_step,
	input  data_t i_dd_norm,
	input  data_t i_dr_mag,
	output data_t o_q_mag,
	output data_t o_r_mag
);

	// stays below the divisor so one word is enough
	data_t rem_q;
	data_t quo_q;
	rem_t  rem_shift;
	rem_t  trial_diff;
	logic  no_borrow;

	// next dividend bit comes off the top of the quotient register
	assign rem_shift = {rem_q, quo_q[DATA_W-1]};

	prefix_subtractor u_sub (
		.i_a        (rem_shift),
		.i_b        ({1'b0, i_dr_mag}),
		.o_diff     (trial_diff),
		.o_no_borrow(no_borrow)
	);

	always_ff @(posedge clk or negedge i_rst) begin
		if (!i_rst) begin
			rem_q <= '0;
			quo_q <= '0;
		end else if (i_init) begin
			rem_q <= '0;
			quo_q <= i_dd_norm;
		end else if (i_step) begin
			// keep the difference only when it did not go negative
			rem_q <= no_borrow ? trial_diff[DATA_W-1:0] : rem_shift[DATA_W-1:0];
			quo_q <= {quo_q[DATA_W-2:0], no_borrow};
		end
	end

	// skipped leading zeros leave zeros in the top quotient bits
	assign o_q_mag = quo_q;
	assign o_r_mag = rem_q;

endmodule

`default_nettype wire

// ==== hw/result_fix.sv ====
`timescale 1ns/1ps
`default_nettype none

module result_fix import div_pkg::*; (
	input  logic  clk,
	input  logic  i_rst,
	input  logic  i_capture,
	input  logic  i_q_neg,
	input  logic  i_r_neg,
	input  data_t i_q_mag,
	input  data_t i_r_mag,
	output data_t o_quotient,
	output data_t o_remainder
);

	data_t q_signed;
	data_t r_signed;

	// two's complement negate where the sign flag asks for it
	assign q_signed = i_q_neg ? data_t'(-i_q_mag) : i_q_mag;
	assign r_signed = i_r_neg ? data_t'(-i_r_mag) : i_r_mag;

	// outputs hold until the next capture
	always_ff @(posedge clk or negedge i_rst) begin
		if (!i_rst) begin
			o_quotient  <= '0;
			o_remainder <= '0;
		end else if (i_capture) begin
			o_quotient  <= q_signed;
			o_remainder <= r_signed;
		end
	end

endmodule

`default_nettype wire

// ==== hw/div_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module div_ctrl import div_pkg::*, div_ctrl_pkg::*; (
	input  logic clk,
	input  logic i_rst,
	input  logic i_start,
	input  cnt_t i_skip,
	output logic o_load,
	output logic o_init,
	output logic o_step,
	output logic o_capture,
	output logic o_busy,
	output logic o_done
);

	div_state_e state;
	cnt_t       step_cnt;
	logic       done_q;

	// start only counts while idle
	assign o_load    = (state == ST_IDLE) && i_start;
	assign o_init    = (state == ST_PREP);
	assign o_step    = (state == ST_ITER) && (step_cnt != '0);
	assign o_capture = (state == ST_FIX);
	assign o_busy    = (state != ST_IDLE);
	assign o_done    = done_q;

	always_ff @(posedge clk or negedge i_rst) begin
		if (!i_rst) begin
			state    <= ST_IDLE;
			step_cnt <= '0;
			done_q   <= 1'b0;
		end else begin
			// one cycle pulse in step with the result capture
			done_q <= (state == ST_FIX);
			case (state)
				ST_IDLE: begin
					if (i_start) begin
						state <= ST_PREP;
					end
				end
				ST_PREP: begin
					step_cnt <= MAX_STEPS - i_skip;
					// zero dividend needs no steps at all
					if (i_skip == MAX_STEPS) begin
						state <= ST_FIX;
					end else begin
						state <= ST_ITER;
					end
				end
				ST_ITER: begin
					if (step_cnt != '0) begin
						step_cnt <= step_cnt - 1'b1;
					end
					// leave on the last step or when nothing is left
					if (step_cnt <= cnt_t'(1)) begin
						state <= ST_FIX;
					end
				end
				ST_FIX: begin
					state <= ST_IDLE;
				end
				default: begin
					state <= ST_IDLE;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== hw/signed_divider.sv ====
`timescale 1ns/1ps
`default_nettype none

module signed_divider import div_pkg::*; (
	input  logic  clk,
	input  logic  i_rst,
	input  logic  i_start,
	input  data_t i_dividend,
	input  data_t i_divisor,
	output logic  o_busy,
	output logic  o_done,
	output data_t o_quotient,
	output data_t o_remainder
);

	logic  load;
	logic  init;
	logic  step;
	logic  capture;
	cnt_t  skip;
	data_t dd_norm;
	data_t dr_mag;
	logic  q_neg;
	logic  r_neg;
	data_t q_mag;
	data_t r_mag;

	div_ctrl u_ctrl (
		.clk(clk), .i_rst(i_rst), .i_start(i_start), .i_skip(skip),
		.o_load(load), .o_init(init), .o_step(step), .o_capture(capture),
		.o_busy(o_busy), .o_done(o_done)
	);

	operand_prep u_prep (
		.clk(clk), .i_rst(i_rst), .i_load(load),
		.i_dividend(i_dividend), .i_divisor(i_divisor),
		.o_dd_norm(dd_norm), .o_dr_mag(dr_mag), .o_skip(skip),
		.o_q_neg(q_neg), .o_r_neg(r_neg)
	);

	restoring_datapath u_dpath (
		.clk(clk), .i_rst(i_rst), .i_init(init), .i_step(step),
		.i_dd_norm(dd_norm), .i_dr_mag(dr_mag),
		.o_q_mag(q_mag), .o_r_mag(r_mag)
	);

	result_fix u_fix (
		.clk(clk), .i_rst(i_rst), .i_capture(capture),
		.i_q_neg(q_neg), .i_r_neg(r_neg), .i_q_mag(q_mag), .i_r_mag(r_mag),
		.o_quotient(o_quotient), .o_remainder(o_remainder)
	);

endmodule

`default_nettype wire

// ==== testbench/tb_signed_divider.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_signed_divider import div_pkg::*; ();

	localparam data_t MIN_VAL     = 32'h8000_0000;
	localparam data_t MAX_VAL     = 32'h7fff_ffff;
	localparam int    NUM_RANDOM  = 300;
	localparam int    DONE_LIMIT  = 100;

	logic  clk;
	logic  i_rst;
	logic  i_start;
	data_t i_dividend;
	data_t i_divisor;
	logic  o_busy;
	logic  o_done;
	data_t o_quotient;
	data_t o_remainder;

	int    checks;
	int    errors;
	int    timeouts;
	int    seed_ret;
	data_t exp_q;
	data_t exp_r;

	signed_divider u_dut (
		.clk(clk), .i_rst(i_rst), .i_start(i_start),
		.i_dividend(i_dividend), .i_divisor(i_divisor),
		.o_busy(o_busy), .o_done(o_done),
		.o_quotient(o_quotient), .o_remainder(o_remainder)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	task automatic finish_run();
		$display("checks %0d, mismatches %0d, timeouts %0d", checks, errors, timeouts);
		if (errors == 0 && timeouts == 0) begin
			$display("Verification passed");
		end else begin
			$display("Verification failed");
		end
		$finish;
	endtask

	task automatic check_quotient(input data_t actual, input data_t expected);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("MISMATCH o_quotient: got %h expected %h", actual, expected);
		end
	endtask

	task automatic check_remainder(input data_t actual, input data_t expected);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("MISMATCH o_remainder: got %h expected %h", actual, expected);
		end
	endtask

	task automatic check_flag(input string name, input logic actual, input logic expected);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("MISMATCH %s: got %h expected %h", name, actual, expected);
		end
	endtask

	// signed division in SV truncates toward zero, remainder follows the dividend
	task automatic compute_expected(input data_t a, input data_t b,
			output data_t q, output data_t r);
		q = data_t'($signed(a) / $signed(b));
		r = data_t'($signed(a) % $signed(b));
	endtask

	// random magnitude width gives a spread of leading zero counts
	task automatic draw_pair(output data_t a, output data_t b);
		data_t ta;
		data_t tb;
		bit    ok;
		ok = 1'b0;
		while (!ok) begin
			ta = $urandom;
			ta = ta >> ($urandom % 32);
			if ($urandom % 2 == 1) ta = data_t'(-ta);
			tb = $urandom;
			tb = tb >> ($urandom % 32);
			if ($urandom % 2 == 1) tb = data_t'(-tb);
			ok = (tb != '0) && !(ta == MIN_VAL && tb == '1);
		end
		a = ta;
		b = tb;
	endtask

	// sampled on the falling edge where outputs are settled
	task automatic wait_done();
		int cycles;
		bit seen;
		seen = 1'b0;
		for (cycles = 0; cycles < DONE_LIMIT && !seen; cycles++) begin
			@(negedge clk);
			if (o_done === 1'b1) seen = 1'b1;
		end
		if (!seen) begin
			timeouts++;
			$display("timeout: o_done did not rise within %0d cycles", DONE_LIMIT);
		end
	endtask

	task automatic start_op(input data_t a, input data_t b);
		@(posedge clk);
		i_dividend <= a;
		i_divisor  <= b;
		i_start    <= 1'b1;
		compute_expected(a, b, exp_q, exp_r);
	endtask

	task automatic check_results(input data_t q, input data_t r);
		check_quotient(o_quotient, q);
		check_remainder(o_remainder, r);
		check_flag("o_busy", o_busy, 1'b0);
	endtask

	// nothing more is started once the DUT has hung
	task automatic run_single(input data_t a, input data_t b);
		if (timeouts != 0) return;
		start_op(a, b);
		@(posedge clk);
		i_start <= 1'b0;
		wait_done();
		if (timeouts == 0) check_results(exp_q, exp_r);
	endtask

	task automatic run_corners();
		run_single(32'd0, 32'd5);
		run_single(32'd0, data_t'(-7));
		run_single(32'd3, 32'd10);
		run_single(data_t'(-3), 32'd10);
		run_single(32'd3, data_t'(-10));
		run_single(MIN_VAL, 32'd1);
		run_single(MIN_VAL, 32'd2);
		run_single(MIN_VAL, data_t'(-2));
		run_single(MIN_VAL, MAX_VAL);
		run_single(MAX_VAL, MIN_VAL);
		run_single(MAX_VAL, 32'd1);
		run_single(32'd17, 32'd5);
		run_single(data_t'(-17), 32'd5);
		run_single(32'd17, data_t'(-5));
		run_single(data_t'(-17), data_t'(-5));
	endtask

	// results hold and no stray pulse while idle
	task automatic check_hold();
		run_single(32'h1234_5678, data_t'(-37));
		if (timeouts != 0) return;
		repeat (10) begin
			@(negedge clk);
			check_flag("o_done", o_done, 1'b0);
			check_flag("o_busy", o_busy, 1'b0);
			check_quotient(o_quotient, exp_q);
			check_remainder(o_remainder, exp_r);
		end
	endtask

	// second start during a long operation must not be taken
	task automatic check_ignored_start();
		start_op(32'h7654_3210, 32'd3);
		@(posedge clk);
		i_start <= 1'b0;
		repeat (2) @(posedge clk);
		i_dividend <= data_t'(-1000);
		i_divisor  <= 32'd7;
		i_start    <= 1'b1;
		@(posedge clk);
		i_start <= 1'b0;
		wait_done();
		if (timeouts != 0) return;
		check_results(exp_q, exp_r);
		repeat (40) begin
			@(negedge clk);
			check_flag("o_done", o_done, 1'b0);
		end
	endtask

	// start stays high so each operation is taken in the first idle cycle
	task automatic run_random_stream();
		data_t a;
		data_t b;
		data_t q_now;
		data_t r_now;
		draw_pair(a, b);
		start_op(a, b);
		@(posedge clk);
		for (int n = 0; n < NUM_RANDOM; n++) begin
			q_now = exp_q;
			r_now = exp_r;
			if (n < NUM_RANDOM - 1) begin
				draw_pair(a, b);
				i_dividend <= a;
				i_divisor  <= b;
				compute_expected(a, b, exp_q, exp_r);
			end else begin
				i_start <= 1'b0;
			end
			@(negedge clk);
			check_flag("o_busy", o_busy, 1'b1);
			wait_done();
			if (timeouts != 0) return;
			check_results(q_now, r_now);
			if (n < NUM_RANDOM - 1) @(posedge clk);
		end
	endtask

	initial begin
		checks     = 0;
		errors     = 0;
		timeouts   = 0;
		i_rst      = 1'b0;
		i_start    = 1'b0;
		i_dividend = '0;
		i_divisor  = '0;
		seed_ret   = $urandom(70177);
		repeat (2) @(posedge clk);
		i_rst <= 1'b1;

		// state right after reset
		@(negedge clk);
		check_flag("o_busy", o_busy, 1'b0);
		check_flag("o_done", o_done, 1'b0);
		check_quotient(o_quotient, '0);
		check_remainder(o_remainder, '0);

		run_corners();
		check_hold();
		if (timeouts == 0) check_ignored_start();
		if (timeouts == 0) run_random_stream();
		finish_run();
	end

endmodule

`default_nettype wire

// ==== signed_divider.f ====
hw/div_pkg.sv
hw/div_ctrl_pkg.sv
hw/operand_prep.sv
hw/prefix_subtractor.sv
hw/restoring_datapath.sv
hw/result_fix.sv
hw/div_ctrl.sv
hw/signed_divider.sv
testbench/tb_signed_divider.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the divider testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f signed_divider.f \
	--top-module tb_signed_divider -Mdir obj_dir
status=$?
if [ "$status" -ne 0 ]; then
	echo "Verilator compile failed with status $status"
	exit 1
fi

output=$(./obj_dir/Vtb_signed_divider)
status=$?
printf '%s\n' "$output"
if [ "$status" -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$output" | grep -qx "Verification passed"; then
	exit 0
fi
exit 1
